// ==== Makefile ====
# Verilator build for the vector execution stage testbench

TOP = tb_vex

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src/vex_decode.sv ====
// Vector micro-op decode
// Maps funct3/funct6 to the ALU op, reduction and scalar flags,
// flags unknown encodings as illegal and builds the active lane vector
`default_nettype none

module vex_decode #(
    parameter int LANES = 8
) (
    input  logic                           valid_i,
    input  vex_pkg::vex_issue_t            issue_i,
    input  vex_pkg::vex_elem_t [LANES-1:0] elem_i,
    output vex_pkg::vex_ctrl_t             ctrl_o,
    output logic [LANES-1:0]               active_o
);
    import vex_pkg::*;

    logic op_ok;

    always_comb begin
        op_ok             = 1'b1;
        ctrl_o.alu_op     = ALU_ADD;
        ctrl_o.is_rdc     = (issue_i.funct3 == F3_OPMVV);
        ctrl_o.use_scalar = (issue_i.funct3 == F3_OPIVX);
        ctrl_o.dst        = issue_i.dst;
        // Reductions start from vs1[0]
        ctrl_o.seed       = elem_i[0].vs1;
        case (issue_i.funct3)
            F3_OPIVV, F3_OPIVX: begin
                case (issue_i.funct6)
                    F6_ADD:  ctrl_o.alu_op = ALU_ADD;
                    F6_SUB:  ctrl_o.alu_op = ALU_SUB;
                    F6_MINU: ctrl_o.alu_op = ALU_MINU;
                    F6_MAXU: ctrl_o.alu_op = ALU_MAXU;
                    F6_AND:  ctrl_o.alu_op = ALU_AND;
                    F6_OR:   ctrl_o.alu_op = ALU_OR;
                    F6_XOR:  ctrl_o.alu_op = ALU_XOR;
                    default: op_ok = 1'b0;
                endcase
            end
            F3_OPMVV: begin
                case (issue_i.funct6)
                    F6_REDSUM:  ctrl_o.alu_op = ALU_ADD;
                    F6_REDAND:  ctrl_o.alu_op = ALU_AND;
                    F6_REDOR:   ctrl_o.alu_op = ALU_OR;
                    F6_REDMAXU: ctrl_o.alu_op = ALU_MAXU;
                    default:    op_ok = 1'b0;
                endcase
            end
            default: op_ok = 1'b0;
        endcase
        ctrl_o.illegal = valid_i && !op_ok;
    end

    // Lane k below vl with its mask set; a vl above LANES covers every lane
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            active_o[k] = valid_i && op_ok && elem_i[k].mask && (k < int'(issue_i.vl));
        end
    end

endmodule

`default_nettype wire

// ==== src/vex_lane.sv ====
// Vector lane, EX1 stage
// Computes the element result for one lane and the value this lane
// feeds into the reduction tree; both are registered at the end of EX1
`default_nettype none

module vex_lane (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_i,
    input  vex_pkg::vex_ctrl_t         ctrl_i,
    input  logic                       active_i,
    input  logic [vex_pkg::DATA_W-1:0] scalar_i,
    input  vex_pkg::vex_elem_t         elem_i,
    output logic [vex_pkg::DATA_W-1:0] res_o,
    output logic [vex_pkg::DATA_W-1:0] leaf_o
);
    import vex_pkg::*;

    logic [DATA_W-1:0] opb;
    logic [DATA_W-1:0] ident;

    // Operand B from vs1 or the broadcast scalar
    assign opb = ctrl_i.use_scalar ? scalar_i : elem_i.vs1;

    // Neutral value, so masked-off lanes drop out of the reduction
    assign ident = (ctrl_i.alu_op == ALU_AND) ? '1 : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_o  <= '0;
            leaf_o <= '0;
        end else if (valid_i) begin
            res_o  <= alu_apply(ctrl_i.alu_op, elem_i.vs2, opb);
            leaf_o <= active_i ? elem_i.vs2 : ident;
        end
    end

endmodule

`default_nettype wire

// ==== src/vex_pkg.sv ====
// Vector execution stage package
// Shared widths, funct3/funct6 encodings, the ALU op enum,
// the issue/element/control structs and the common ALU function
`default_nettype none

package vex_pkg;

    localparam int DATA_W = 32;
    localparam int REG_AW = 5;
    localparam int VL_W   = 5;

    //--------------------------------------------------
    // funct3 groups
    //--------------------------------------------------
    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPIVX = 3'b100;
    localparam logic [2:0] F3_OPMVV = 3'b010;

    // Element ops, OPIVV / OPIVX
    localparam logic [5:0] F6_ADD  = 6'b000000;
    localparam logic [5:0] F6_SUB  = 6'b000010;
    localparam logic [5:0] F6_MINU = 6'b000100;
    localparam logic [5:0] F6_MAXU = 6'b000110;
    localparam logic [5:0] F6_AND  = 6'b001001;
    localparam logic [5:0] F6_OR   = 6'b001010;
    localparam logic [5:0] F6_XOR  = 6'b001011;

    // Reductions, OPMVV
    localparam logic [5:0] F6_REDSUM  = 6'b000000;
    localparam logic [5:0] F6_REDAND  = 6'b000001;
    localparam logic [5:0] F6_REDOR   = 6'b000010;
    localparam logic [5:0] F6_REDMAXU = 6'b000110;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MINU,
        ALU_MAXU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } vex_alu_op_e;

    typedef struct packed {
        logic [REG_AW-1:0] dst;
        logic [5:0]        funct6;
        logic [2:0]        funct3;
        logic [VL_W-1:0]   vl;
        logic [DATA_W-1:0] scalar;
    } vex_issue_t;

    typedef struct packed {
        logic [DATA_W-1:0] vs2;
        logic [DATA_W-1:0] vs1;
        logic              mask;
    } vex_elem_t;

    typedef struct packed {
        vex_alu_op_e       alu_op;
        logic              is_rdc;
        logic              use_scalar;
        logic              illegal;
        logic [REG_AW-1:0] dst;
        logic [DATA_W-1:0] seed;
    } vex_ctrl_t;

    // One ALU shared by the lanes, the tree levels and the final seed fold
    function automatic logic [DATA_W-1:0] alu_apply(vex_alu_op_e op,
                                                    logic [DATA_W-1:0] a,
                                                    logic [DATA_W-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_MINU: return (a < b) ? a : b;
            ALU_MAXU: return (a > b) ? a : b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            default:  return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/vex_reduce_tree.sv ====
// Pipelined cross-lane reduction tree
// Each level folds lane pairs (k, k+half) with the op and registers
// the partial values; op and valid travel with every level
`default_nettype none

module vex_reduce_tree #(
    parameter int LANES = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   valid_i,
    input  vex_pkg::vex_alu_op_e                   op_i,
    input  logic [LANES-1:0][vex_pkg::DATA_W-1:0]  leaf_i,
    output logic [vex_pkg::DATA_W-1:0]             sum_o
);
    import vex_pkg::*;

    localparam int LVL = $clog2(LANES);

    // Start index of level l in the node view, leaves are level 0
    function automatic int base(int l);
        return 2 * LANES - ((2 * LANES) >> l);
    endfunction

    logic [LVL-1:0]    v_q;
    vex_alu_op_e       op_q [LVL];
    logic [DATA_W-1:0] node_q [LANES-1];
    logic [DATA_W-1:0] node [2*LANES-1];

    //--------------------------------------------------
    // Level control
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_q <= '0;
        end else begin
            v_q[0] <= valid_i;
            for (int l = 1; l < LVL; l++) begin
                v_q[l] <= v_q[l-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            op_q[0] <= op_i;
        end
        for (int l = 1; l < LVL; l++) begin
            if (v_q[l-1]) begin
                op_q[l] <= op_q[l-1];
            end
        end
    end

    //--------------------------------------------------
    // Partial values
    //--------------------------------------------------
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            node[k] = leaf_i[k];
        end
        for (int k = 0; k < LANES - 1; k++) begin
            node[LANES+k] = node_q[k];
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 1; l <= LVL; l++) begin
            if (v_q[l-1]) begin
                for (int k = 0; k < (LANES >> l); k++) begin
                    node_q[base(l)-LANES+k] <= alu_apply(op_q[l-1], node[base(l-1)+k],
                                                         node[base(l-1)+k+(LANES>>l)]);
                end
            end
        end
    end

    // Root of the last level
    assign sum_o = node_q[LANES-2];

endmodule

`default_nettype wire

// ==== src/vex_top.sv ====
// Integer vector execution stage
// Decode, per-lane EX1 ALUs, pipelined reduction tree and writeback;
// fixed latency of log2(LANES)+1 cycles, one micro-op per cycle
`default_nettype none

module vex_top #(
    parameter int LANES = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_i,
    input  vex_pkg::vex_issue_t                   issue_i,
    input  vex_pkg::vex_elem_t [LANES-1:0]        elem_i,
    output logic [LANES-1:0]                      wr_en_o,
    output logic [vex_pkg::REG_AW-1:0]            wr_addr_o,
    output logic [LANES-1:0][vex_pkg::DATA_W-1:0] wr_data_o,
    output logic                                  illegal_o,
    output logic                                  idle_o
);
    import vex_pkg::*;

    vex_ctrl_t                    ctrl;
    logic [LANES-1:0]             active;
    logic [LANES-1:0][DATA_W-1:0] res;
    logic [LANES-1:0][DATA_W-1:0] leaf;
    logic [DATA_W-1:0]            tree_sum;
    logic                         busy;

    vex_decode #(
        .LANES(LANES)
    ) u_decode (
        .valid_i (valid_i),
        .issue_i (issue_i),
        .elem_i  (elem_i),
        .ctrl_o  (ctrl),
        .active_o(active)
    );

    //--------------------------------------------------
    // Lane array
    //--------------------------------------------------
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        vex_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .valid_i (valid_i),
            .ctrl_i  (ctrl),
            .active_i(active[k]),
            .scalar_i(issue_i.scalar),
            .elem_i  (elem_i[k]),
            .res_o   (res[k]),
            .leaf_o  (leaf[k])
        );
    end

    vex_reduce_tree #(
        .LANES(LANES)
    ) u_tree (
        .clk    (clk),
        .rst_n  (rst_n),
        .valid_i(valid_i),
        .op_i   (ctrl.alu_op),
        .leaf_i (leaf),
        .sum_o  (tree_sum)
    );

    vex_writeback #(
        .LANES(LANES)
    ) u_wb (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (valid_i),
        .ctrl_i   (ctrl),
        .active_i (active),
        .res_i    (res),
        .tree_i   (tree_sum),
        .wr_en_o  (wr_en_o),
        .wr_addr_o(wr_addr_o),
        .wr_data_o(wr_data_o),
        .illegal_o(illegal_o),
        .busy_o   (busy)
    );

    // Nothing in flight and nothing offered this cycle
    assign idle_o = ~(busy | valid_i);

endmodule

`default_nettype wire

// ==== src/vex_writeback.sv ====
// Vector writeback
// Delays control, active lanes and element results to meet the tree
// output, folds the reduction seed and drives the register file port
`default_nettype none

module vex_writeback #(
    parameter int LANES = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_i,
    input  vex_pkg::vex_ctrl_t                    ctrl_i,
    input  logic [LANES-1:0]                      active_i,
    input  logic [LANES-1:0][vex_pkg::DATA_W-1:0] res_i,
    input  logic [vex_pkg::DATA_W-1:0]            tree_i,
    output logic [LANES-1:0]                      wr_en_o,
    output logic [vex_pkg::REG_AW-1:0]            wr_addr_o,
    output logic [LANES-1:0][vex_pkg::DATA_W-1:0] wr_data_o,
    output logic                                  illegal_o,
    output logic                                  busy_o
);
    import vex_pkg::*;

    localparam int LVL = $clog2(LANES);

    // Stage 0 is the EX1/EX2 register, stage LVL lines up with tree_i
    logic [LVL:0]                 v_q;
    vex_ctrl_t                    c_q [LVL+1];
    logic [LANES-1:0]             a_q [LVL+1];
    logic [LANES-1:0][DATA_W-1:0] r_q [1:LVL];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_q <= '0;
        end else begin
            v_q <= {v_q[LVL-1:0], valid_i};
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            c_q[0] <= ctrl_i;
            a_q[0] <= active_i;
        end
        if (v_q[0]) begin
            r_q[1] <= res_i;
        end
        for (int s = 1; s <= LVL; s++) begin
            if (v_q[s-1]) begin
                c_q[s] <= c_q[s-1];
                a_q[s] <= a_q[s-1];
            end
        end
        for (int s = 2; s <= LVL; s++) begin
            if (v_q[s-1]) begin
                r_q[s] <= r_q[s-1];
            end
        end
    end

    //--------------------------------------------------
    // Output select
    //--------------------------------------------------
    always_comb begin
        wr_en_o   = '0;
        wr_data_o = r_q[LVL];
        illegal_o = v_q[LVL] && c_q[LVL].illegal;
        if (v_q[LVL] && !c_q[LVL].illegal) begin
            if (c_q[LVL].is_rdc) begin
                // Scalar result in lane 0 only
                wr_en_o[0]   = 1'b1;
                wr_data_o    = '0;
                wr_data_o[0] = alu_apply(c_q[LVL].alu_op, tree_i, c_q[LVL].seed);
            end else begin
                wr_en_o = a_q[LVL];
            end
        end
    end

    assign wr_addr_o = c_q[LVL].dst;
    assign busy_o    = |v_q;

endmodule

`default_nettype wire

// ==== include/vex_tb_ref.svh ====
// Reference model for the vector execution stage testbench
// Legality, expected write enables, element results and reductions,
// computed directly from the issued micro-op fields
`ifndef VEX_TB_REF_SVH
`define VEX_TB_REF_SVH

localparam int TB_LANES = 8;

typedef logic [TB_LANES-1:0][vex_pkg::DATA_W-1:0] ref_data_t;
typedef vex_pkg::vex_elem_t [TB_LANES-1:0]        ref_elem_t;

function automatic bit ref_legal(vex_pkg::vex_issue_t iss);
    case (iss.funct3)
        vex_pkg::F3_OPIVV, vex_pkg::F3_OPIVX:
            return iss.funct6 inside {vex_pkg::F6_ADD, vex_pkg::F6_SUB, vex_pkg::F6_MINU,
                                      vex_pkg::F6_MAXU, vex_pkg::F6_AND, vex_pkg::F6_OR,
                                      vex_pkg::F6_XOR};
        vex_pkg::F3_OPMVV:
            return iss.funct6 inside {vex_pkg::F6_REDSUM, vex_pkg::F6_REDAND,
                                      vex_pkg::F6_REDOR, vex_pkg::F6_REDMAXU};
        default:
            return 1'b0;
    endcase
endfunction

// Mask bits below vl, vl above TB_LANES covers all lanes
function automatic logic [TB_LANES-1:0] ref_wr_en(vex_pkg::vex_issue_t iss, ref_elem_t el);
    logic [TB_LANES-1:0] en;
    en = '0;
    for (int k = 0; k < TB_LANES; k++) begin
        en[k] = el[k].mask && (k < int'(iss.vl));
    end
    return en;
endfunction

function automatic logic [31:0] ref_elem_op(logic [5:0] f6, logic [31:0] a, logic [31:0] b);
    case (f6)
        vex_pkg::F6_ADD:  return a + b;
        vex_pkg::F6_SUB:  return a - b;
        vex_pkg::F6_MINU: return (a < b) ? a : b;
        vex_pkg::F6_MAXU: return (a > b) ? a : b;
        vex_pkg::F6_AND:  return a & b;
        vex_pkg::F6_OR:   return a | b;
        vex_pkg::F6_XOR:  return a ^ b;
        default:          return '0;
    endcase
endfunction

function automatic ref_data_t ref_elem_data(vex_pkg::vex_issue_t iss, ref_elem_t el);
    ref_data_t   d;
    logic [31:0] b;
    for (int k = 0; k < TB_LANES; k++) begin
        b    = (iss.funct3 == vex_pkg::F3_OPIVX) ? iss.scalar : el[k].vs1;
        d[k] = ref_elem_op(iss.funct6, el[k].vs2, b);
    end
    return d;
endfunction

// Fold of the active vs2 elements onto the vs1[0] seed
function automatic logic [31:0] ref_rdc(vex_pkg::vex_issue_t iss, ref_elem_t el);
    logic [31:0]         acc;
    logic [TB_LANES-1:0] en;
    acc = el[0].vs1;
    en  = ref_wr_en(iss, el);
    for (int k = 0; k < TB_LANES; k++) begin
        if (en[k]) begin
            case (iss.funct6)
                vex_pkg::F6_REDSUM:  acc = acc + el[k].vs2;
                vex_pkg::F6_REDAND:  acc = acc & el[k].vs2;
                vex_pkg::F6_REDOR:   acc = acc | el[k].vs2;
                vex_pkg::F6_REDMAXU: acc = (el[k].vs2 > acc) ? el[k].vs2 : acc;
                default:             acc = acc;
            endcase
        end
    end
    return acc;
endfunction

`endif

// ==== test/tb_vex.sv ====
// Testbench for the integer vector execution stage
// Drives element ops, masked ops, reductions and a back-to-back mix,
// checks every result against the reference model at the fixed latency
`default_nettype none

module tb_vex;
    `include "vex_tb_ref.svh"

    localparam int N_ELEM  = 40;
    localparam int N_MASK  = 40;
    localparam int N_RDC   = 8;
    localparam int N_MIX   = 40;
    localparam int N_OPS   = N_ELEM + N_MASK + 4 * N_RDC + N_MIX;
    localparam int TIMEOUT = (N_OPS + 20) * 20 * 2;

    localparam logic [1:0] K_ELEM = 2'd0;
    localparam logic [1:0] K_RDC  = 2'd1;
    localparam logic [1:0] K_ILL  = 2'd2;

    localparam logic [5:0] ELEM_F6 [7] = '{vex_pkg::F6_ADD, vex_pkg::F6_SUB, vex_pkg::F6_MINU,
                                           vex_pkg::F6_MAXU, vex_pkg::F6_AND, vex_pkg::F6_OR,
                                           vex_pkg::F6_XOR};
    localparam logic [5:0] RDC_F6 [4]  = '{vex_pkg::F6_REDSUM, vex_pkg::F6_REDAND,
                                           vex_pkg::F6_REDOR, vex_pkg::F6_REDMAXU};

    typedef struct packed {
        logic [1:0]                 kind;
        logic [vex_pkg::REG_AW-1:0] dst;
        logic [TB_LANES-1:0]        en;
        ref_data_t                  data;
        logic [31:0]                due;
    } exp_t;

    logic                       clk;
    logic                       rst_n;
    logic                       valid_i;
    vex_pkg::vex_issue_t        issue_i;
    ref_elem_t                  elem_i;
    logic [TB_LANES-1:0]        wr_en_o;
    logic [vex_pkg::REG_AW-1:0] wr_addr_o;
    ref_data_t                  wr_data_o;
    logic                       illegal_o;
    logic                       idle_o;

    exp_t exp_q [$];
    int   cyc     = 0;
    int   err_cnt = 0;
    int   chk_cnt = 0;
    int   n_tests = 0;

    vex_top #(
        .LANES(TB_LANES)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (valid_i),
        .issue_i  (issue_i),
        .elem_i   (elem_i),
        .wr_en_o  (wr_en_o),
        .wr_addr_o(wr_addr_o),
        .wr_data_o(wr_data_o),
        .illegal_o(illegal_o),
        .idle_o   (idle_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("TB FAILED");
        $finish;
    end

    //--------------------------------------------------
    // Error reporting and compare tasks
    //--------------------------------------------------
    task automatic flag_error(input string msg);
        $display("FAIL t=%0t %s", $time, msg);
        err_cnt++;
    endtask

    task automatic check_elem(input logic [TB_LANES-1:0] en,
                              input logic [vex_pkg::REG_AW-1:0] dst, input ref_data_t data);
        chk_cnt++;
        if (illegal_o !== 1'b0) flag_error("illegal_o set for a legal element op");
        if (wr_en_o !== en) flag_error($sformatf("wr_en %b, expected %b", wr_en_o, en));
        if (wr_addr_o !== dst) flag_error($sformatf("wr_addr %0d, expected %0d", wr_addr_o, dst));
        for (int k = 0; k < TB_LANES; k++) begin
            if (en[k] && wr_data_o[k] !== data[k]) begin
                flag_error($sformatf("lane %0d data %h, expected %h", k, wr_data_o[k], data[k]));
            end
        end
    endtask

    task automatic check_rdc(input logic [vex_pkg::DATA_W-1:0] exp_val,
                             input logic [vex_pkg::REG_AW-1:0] dst);
        chk_cnt++;
        if (illegal_o !== 1'b0) flag_error("illegal_o set for a reduction");
        if (wr_en_o !== TB_LANES'(1)) flag_error($sformatf("reduction wr_en %b", wr_en_o));
        if (wr_addr_o !== dst) flag_error($sformatf("wr_addr %0d, expected %0d", wr_addr_o, dst));
        if (wr_data_o[0] !== exp_val) begin
            flag_error($sformatf("reduction %h, expected %h", wr_data_o[0], exp_val));
        end
        for (int k = 1; k < TB_LANES; k++) begin
            if (wr_data_o[k] !== '0) flag_error($sformatf("lane %0d not zero", k));
        end
    endtask

    task automatic check_illegal();
        chk_cnt++;
        if (illegal_o !== 1'b1) flag_error("illegal_o not pulsed for an unknown encoding");
        if (wr_en_o !== '0) flag_error($sformatf("illegal op wrote lanes %b", wr_en_o));
    endtask

    task automatic check_idle(input logic exp_idle);
        chk_cnt++;
        if (idle_o !== exp_idle) begin
            flag_error($sformatf("idle_o %b, expected %b", idle_o, exp_idle));
        end
    endtask

    // Results are stable around the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (rst_n) begin
            // Any queued op is still in the pipeline
            check_idle(exp_q.size() == 0);
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                case (e.kind)
                    K_ELEM:  check_elem(e.en, e.dst, e.data);
                    K_RDC:   check_rdc(e.data[0], e.dst);
                    default: check_illegal();
                endcase
            end else if (wr_en_o !== '0 || illegal_o !== 1'b0) begin
                flag_error("output seen with no op due");
            end
        end
    end

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------
    task automatic send_op(input logic [5:0] f6, input logic [2:0] f3,
                           input logic [vex_pkg::VL_W-1:0] vl, input logic [TB_LANES-1:0] mask);
        vex_pkg::vex_issue_t iss;
        ref_elem_t           el;
        exp_t                e;
        @(posedge clk);
        #2;
        iss.dst    = 5'($urandom);
        iss.funct6 = f6;
        iss.funct3 = f3;
        iss.vl     = vl;
        iss.scalar = $urandom;
        for (int k = 0; k < TB_LANES; k++) begin
            el[k].vs2  = $urandom;
            el[k].vs1  = $urandom;
            el[k].mask = mask[k];
        end
        e      = '0;
        e.dst  = iss.dst;
        e.due  = cyc + 4;
        if (!ref_legal(iss)) begin
            e.kind = K_ILL;
        end else if (f3 == vex_pkg::F3_OPMVV) begin
            e.kind    = K_RDC;
            e.data[0] = ref_rdc(iss, el);
        end else begin
            e.kind = K_ELEM;
            e.en   = ref_wr_en(iss, el);
            e.data = ref_elem_data(iss, el);
        end
        valid_i = 1'b1;
        issue_i = iss;
        elem_i  = el;
        exp_q.push_back(e);
    endtask

    task automatic drain();
        @(posedge clk);
        #2;
        valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (err_cnt == errs_before) begin
            $display("test %-8s ok", name);
        end else begin
            $display("test %-8s %0d errors", name, err_cnt - errs_before);
        end
    endtask

    function automatic logic [2:0] pick_f3();
        return ($urandom % 2 == 0) ? vex_pkg::F3_OPIVV : vex_pkg::F3_OPIVX;
    endfunction

    initial begin
        int e0;
        int pick;
        void'($urandom(32'h2c81));
        rst_n   = 1'b0;
        valid_i = 1'b0;
        issue_i = '0;
        elem_i  = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        e0 = err_cnt;
        chk_cnt++;
        if (wr_en_o !== '0 || illegal_o !== 1'b0 || idle_o !== 1'b1) begin
            flag_error("outputs not in reset state");
        end
        report_test("reset", e0);

        e0 = err_cnt;
        for (int i = 0; i < N_ELEM; i++) begin
            send_op(ELEM_F6[i % 7], pick_f3(), 5'd8, '1);
        end
        drain();
        report_test("element", e0);

        e0 = err_cnt;
        for (int i = 0; i < N_MASK; i++) begin
            send_op(ELEM_F6[$urandom % 7], pick_f3(), 5'($urandom % 11), 8'($urandom));
        end
        drain();
        report_test("mask_vl", e0);

        e0 = err_cnt;
        for (int op = 0; op < 4; op++) begin
            for (int i = 0; i < N_RDC; i++) begin
                send_op(RDC_F6[op], vex_pkg::F3_OPMVV, 5'($urandom % 11), 8'($urandom));
            end
        end
        drain();
        report_test("reduce", e0);

        // Element, reduction and unknown encodings on every cycle
        e0 = err_cnt;
        for (int i = 0; i < N_MIX; i++) begin
            pick = $urandom % 5;
            case (pick)
                0, 1:    send_op(ELEM_F6[$urandom % 7], pick_f3(), 5'($urandom % 11),
                                 8'($urandom));
                2, 3:    send_op(RDC_F6[$urandom % 4], vex_pkg::F3_OPMVV, 5'($urandom % 11),
                                 8'($urandom));
                default: send_op(6'b111111, (i % 2 == 0) ? 3'b001 : vex_pkg::F3_OPMVV, 5'd8,
                                 '1);
            endcase
        end
        drain();
        @(posedge clk);
        #2;
        chk_cnt++;
        if (idle_o !== 1'b1) flag_error("idle_o did not return to 1 after the last op");
        report_test("mixed", e0);

        $display("tests %0d, checks %0d, errors %0d", n_tests, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/vex_pkg.sv
src/vex_decode.sv
src/vex_lane.sv
src/vex_reduce_tree.sv
src/vex_writeback.sv
src/vex_top.sv
test/tb_vex.sv
